//--- logic/hdc_defines.svh
`ifndef HDC_DEFINES_SVH
`define HDC_DEFINES_SVH

// hypervector width in bits, a multiple of 32
`define HDC_DIM 64

// item memory depth
`define HDC_ITEMS 16

// hardware threads sharing the datapath
`define HDC_THREADS 5

// xorshift32 state after reset
`define HDC_PRNG_SEED 32'h2545F491

`endif

//--- logic/hdc_hv_pkg.sv
`include "hdc_defines.svh"

package hdc_hv_pkg;

    // one hypervector
    typedef logic [`HDC_DIM-1:0] hv_t;

    // one xorshift32 output word
    typedef logic [31:0] rand_word_t;

    typedef logic [3:0] item_addr_t;

    typedef logic [2:0] thread_id_t;

    // item memory fill sequencer
    typedef enum logic [1:0] {
        FILL_IDLE = 2'd0,
        FILL_RUN  = 2'd1,
        FILL_DONE = 2'd2
    } fill_state_t;

endpackage

//--- logic/hdc_isa_pkg.sv
`include "hdc_defines.svh"

package hdc_isa_pkg;

    // 16-bit instruction word, msb first
    typedef struct packed {
        logic       load;
        logic       permute;
        logic       bind_acc;
        logic       store;
        logic       set_bind;
        logic       spare;
        logic [9:0] operand;
    } hdc_instr_t;

    // rotate distance, operand modulo the width
    typedef logic [$clog2(`HDC_DIM)-1:0] rot_amt_t;

endpackage

//--- logic/xorshift_prng.sv
`timescale 1ns/1ps
`include "hdc_defines.svh"

module xorshift_prng
    import hdc_hv_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       gen,
    input  logic       reset_prng,
    output rand_word_t rand_word
);

    rand_word_t state;
    rand_word_t mix_a;
    rand_word_t mix_b;
    rand_word_t next_state;

    // xorshift32 with shifts 13, 17, 5
    always_comb begin
        mix_a      = state ^ (state << 13);
        mix_b      = mix_a ^ (mix_a >> 17);
        next_state = mix_b ^ (mix_b << 5);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rand_word_t'(`HDC_PRNG_SEED);
        end else if (reset_prng) begin
            state <= rand_word_t'(`HDC_PRNG_SEED);
        end else if (gen) begin
            state <= next_state;
        end
    end

    assign rand_word = state;

endmodule

//--- logic/item_fill.sv
`timescale 1ns/1ps
`include "hdc_defines.svh"

module item_fill
    import hdc_hv_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       gen,
    input  logic       reset_prng,
    input  item_addr_t item_count,
    output logic       item_we,
    output item_addr_t item_waddr,
    output hv_t        item_wdata,
    output logic       gen_done
);

    localparam int WORDS  = `HDC_DIM / 32;
    localparam int WIDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;

    fill_state_t       state;
    logic [WIDX_W-1:0] word_idx;
    item_addr_t        item_idx;
    rand_word_t        rand_word;
    hv_t               shadow;
    logic              last_word;

    xorshift_prng prng_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .gen        (gen),
        .reset_prng (reset_prng),
        .rand_word  (rand_word)
    );

    assign last_word  = (word_idx == WIDX_W'(WORDS - 1));
    assign item_wdata = shadow;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= FILL_IDLE;
            word_idx <= '0;
            item_idx <= '0;
            item_we  <= 1'b0;
            gen_done <= 1'b0;
        end else begin
            item_we  <= 1'b0;
            gen_done <= 1'b0;
            if (!gen) begin
                state    <= FILL_IDLE;
                word_idx <= '0;
                item_idx <= '0;
            end else begin
                case (state)
                    // generator takes its first step here
                    FILL_IDLE: state <= FILL_RUN;
                    FILL_RUN: begin
                        if (last_word) begin
                            word_idx <= '0;
                            item_we  <= 1'b1;
                            item_idx <= item_idx + 1'b1;
                            if (item_idx == item_addr_t'(item_count - 1'b1)) begin
                                gen_done <= 1'b1;
                                state    <= FILL_DONE;
                            end
                        end else begin
                            word_idx <= word_idx + 1'b1;
                        end
                    end
                    // parked until gen falls
                    FILL_DONE: state <= FILL_DONE;
                    default:   state <= FILL_IDLE;
                endcase
            end
        end
    end

    // word k lands at bits 32k upward
    always_ff @(posedge clk) begin
        if (gen && state == FILL_RUN) begin
            shadow[int'(word_idx) * 32 +: 32] <= rand_word;
            if (last_word) begin
                item_waddr <= item_idx;
            end
        end
    end

endmodule

//--- logic/hv_thread_regs.sv
`timescale 1ns/1ps
`include "hdc_defines.svh"

module hv_thread_regs
    import hdc_hv_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    input  logic advance,
    input  logic acc_we,
    input  hv_t  acc_wdata,
    input  logic bind_we,
    input  hv_t  bind_wdata,
    output hv_t  acc_q,
    output hv_t  bind_q
);

    localparam thread_id_t LAST_TID = thread_id_t'(`HDC_THREADS - 1);

    hv_t        acc_bank  [`HDC_THREADS];
    hv_t        bind_bank [`HDC_THREADS];
    thread_id_t ptr;
    thread_id_t exec_tid;

    // round-robin pointer, parked at thread 0 while stopped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr      <= '0;
            exec_tid <= '0;
        end else if (!run) begin
            ptr <= '0;
        end else if (advance) begin
            exec_tid <= ptr;
            if (ptr == LAST_TID) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    // prefetch the incoming thread, write back the one executing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `HDC_THREADS; i++) begin
                acc_bank[i]  <= '0;
                bind_bank[i] <= '0;
            end
            acc_q  <= '0;
            bind_q <= '0;
        end else begin
            if (acc_we) begin
                acc_bank[exec_tid] <= acc_wdata;
            end
            if (bind_we) begin
                bind_bank[exec_tid] <= bind_wdata;
            end
            if (run && advance) begin
                acc_q  <= acc_bank[ptr];
                bind_q <= bind_bank[ptr];
            end
        end
    end

endmodule

//--- logic/hdc_core.sv
`timescale 1ns/1ps
`include "hdc_defines.svh"

module hdc_core
    import hdc_hv_pkg::*;
    import hdc_isa_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    input  logic       gen,
    input  logic       reset_prng,
    input  item_addr_t item_count,
    input  logic       instr_valid,
    input  hdc_instr_t instr,
    output logic       gen_done,
    output logic       result_valid,
    output hv_t        result
);

    hv_t        item_mem [`HDC_ITEMS];
    hv_t        item_q;
    logic       item_we;
    item_addr_t item_waddr;
    hv_t        item_wdata;

    logic       accept;
    logic       pend;
    logic       commit;
    hdc_instr_t instr_q;

    hv_t        acc_q;
    hv_t        bind_q;
    hv_t        rotated;
    rot_amt_t   rot_amt;
    logic       acc_we;
    hv_t        acc_wdata;
    logic       bind_we;

    logic       store_q;
    hv_t        result_q;

    assign accept = run & instr_valid;
    // dropping run cancels whatever is in flight
    assign commit = pend & run;

    item_fill fill_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .gen        (gen),
        .reset_prng (reset_prng),
        .item_count (item_count),
        .item_we    (item_we),
        .item_waddr (item_waddr),
        .item_wdata (item_wdata),
        .gen_done   (gen_done)
    );

    always_ff @(posedge clk) begin
        if (item_we) begin
            item_mem[item_waddr] <= item_wdata;
        end
        if (accept) begin
            item_q <= item_mem[instr.operand[$bits(item_addr_t)-1:0]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= 1'b0;
        end else begin
            pend <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr;
        end
    end

    hv_thread_regs regs_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .advance    (accept),
        .acc_we     (acc_we),
        .acc_wdata  (acc_wdata),
        .bind_we    (bind_we),
        .bind_wdata (rotated),
        .acc_q      (acc_q),
        .bind_q     (bind_q)
    );

    // permute is a left rotate of the accumulator
    always_comb begin
        rot_amt = rot_amt_t'(int'(instr_q.operand) % `HDC_DIM);
        if (instr_q.permute) begin
            rotated = (acc_q << rot_amt) | (acc_q >> (`HDC_DIM - int'(rot_amt)));
        end else begin
            rotated = acc_q;
        end
    end

    // load wins over every other field
    always_comb begin
        acc_we    = commit & (instr_q.load | instr_q.bind_acc);
        acc_wdata = instr_q.load ? item_q : (bind_q ^ rotated);
        bind_we   = commit & ~instr_q.load & instr_q.set_bind;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            store_q <= 1'b0;
        end else begin
            store_q <= commit & ~instr_q.load & instr_q.store;
        end
    end

    always_ff @(posedge clk) begin
        if (commit && instr_q.store) begin
            result_q <= rotated;
        end
    end

    assign result_valid = store_q & run;
    assign result       = result_valid ? result_q : '0;

endmodule

//--- logic/hdc_top.sv
`timescale 1ns/1ps

module hdc_top
    import hdc_hv_pkg::*;
    import hdc_isa_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    input  logic       gen,
    input  logic       reset_prng,
    input  item_addr_t item_count,
    input  logic       instr_valid,
    input  hdc_instr_t instr,
    output logic       gen_done,
    output logic       result_valid,
    output hv_t        result
);

    // single core for now
    hdc_core core_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .gen          (gen),
        .reset_prng   (reset_prng),
        .item_count   (item_count),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .gen_done     (gen_done),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

//--- dv/hdc_assert.sv
`timescale 1ns/1ps

module hdc_assert
    import hdc_isa_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       run,
    input logic       instr_valid,
    input hdc_instr_t instr,
    input logic       gen_done,
    input logic       result_valid
);

    // running count of failed properties
    int fail_count = 0;

    // no result without an accept and a commit while running
    a_quiet_when_stopped: assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid |-> ($past(run) && $past(run && instr_valid, 2))
    ) else begin
        $error("result_valid high without a running accept and commit");
        fail_count++;
    end

    a_gen_done_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) gen_done |=> !gen_done
    ) else begin
        $error("gen_done held for more than one cycle");
        fail_count++;
    end

    // a store shows up two edges after acceptance and nothing else does
    a_store_timing: assert property (
        @(posedge clk) disable iff (!rst_n)
        (run && $past(run) && $past(run && instr_valid, 2))
            |-> (result_valid == $past(instr.store && !instr.load, 2))
    ) else begin
        $error("result_valid does not follow the accepted instruction");
        fail_count++;
    end

endmodule

bind hdc_core hdc_assert assert_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .run          (run),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .gen_done     (gen_done),
    .result_valid (result_valid)
);

//--- dv/hdc_tb.sv
`timescale 1ns/1ps
`include "hdc_defines.svh"

module hdc_tb
    import hdc_hv_pkg::*;
    import hdc_isa_pkg::*;
();

    localparam int WORDS = `HDC_DIM / 32;

    logic       clk;
    logic       rst_n;
    logic       run;
    logic       gen;
    logic       reset_prng;
    item_addr_t item_count;
    logic       instr_valid;
    hdc_instr_t instr;
    logic       gen_done;
    logic       result_valid;
    hv_t        result;

    // case file contents
    logic [15:0] case_word[$];
    int          case_flag[$];
    hv_t         case_exp[$];
    int          item_total;

    hv_t exp_queue[$];
    int  cycle_count = 0;
    int  cycle_limit = 1000;

    hdc_top hdc_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .gen          (gen),
        .reset_prng   (reset_prng),
        .item_count   (item_count),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .gen_done     (gen_done),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input hv_t got, input hv_t expected);
        if (got !== expected) begin
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          code;
        int          flag;
        bit          have_count;
        string       line;
        logic [15:0] word;
        hv_t         expected;
        fd = $fopen("dv/hdc_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open dv/hdc_cases.txt");
        end
        have_count = 1'b0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if (!have_count) begin
                code = $sscanf(line, "%d", item_total);
                have_count = 1'b1;
            end else begin
                code = $sscanf(line, "%h %d %h", word, flag, expected);
                if (code != 3) begin
                    abort_run({"malformed case line: ", line});
                end
                case_word.push_back(word);
                case_flag.push_back(flag);
                case_exp.push_back(expected);
            end
        end
        $fclose(fd);
    endtask

    // each step lands 2 ns after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic drain_results();
        while (exp_queue.size() != 0) begin
            wait_cycles(1);
        end
        wait_cycles(2);
    endtask

    task automatic restart_run();
        drain_results();
        run = 1'b0;
        wait_cycles(3);
        run = 1'b1;
    endtask

    task automatic check_fill();
        int cycles;
        int pulses;
        gen = 1'b1;
        cycles = 0;
        do begin
            wait_cycles(1);
            cycles++;
        end while (!gen_done);
        check_value("gen_done delay", hv_t'(cycles), hv_t'(WORDS * item_total + 1));
        pulses = 1;
        repeat (4) begin
            wait_cycles(1);
            if (gen_done) begin
                pulses++;
            end
        end
        check_value("gen_done pulses", hv_t'(pulses), hv_t'(1));
        @(posedge clk);
        #2;
        gen = 1'b0;
    endtask

    // results come back in issue order
    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            if (exp_queue.size() == 0) begin
                abort_run("result_valid high with no store outstanding");
            end else begin
                check_value("result", result, exp_queue.pop_front());
            end
        end else if (rst_n) begin
            // idle result bus reads zero
            check_value("result", result, '0);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    initial begin
        int gap;
        rst_n       = 1'b0;
        run         = 1'b0;
        gen         = 1'b0;
        reset_prng  = 1'b0;
        item_count  = '0;
        instr_valid = 1'b0;
        instr       = '0;
        void'($urandom(88));
        load_cases();
        cycle_limit = 200 + 4 * (WORDS * item_total + 1 + case_word.size());
        item_count  = item_addr_t'(item_total);

        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("result_valid", hv_t'(result_valid), '0);
        check_value("gen_done", hv_t'(gen_done), '0);
        check_value("result", result, '0);

        @(posedge clk);
        #2;
        check_fill();
        run = 1'b1;

        foreach (case_word[i]) begin
            if (case_flag[i][1]) begin
                restart_run();
            end
            instr_valid = 1'b1;
            instr       = hdc_instr_t'(case_word[i]);
            if (case_flag[i][0]) begin
                exp_queue.push_back(case_exp[i]);
            end
            wait_cycles(1);
            instr_valid = 1'b0;
            instr       = '0;
            gap = int'($urandom % 4);
            wait_cycles(gap);
        end

        drain_results();
        wait_cycles(4);
        check_value("assertion failures",
                    hv_t'(hdc_top_inst.core_inst.assert_inst.fail_count), '0);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- dv/hdc_cases.txt
# first data line: number of items to generate
# then: instruction (hex), flags (bit0 store expected, bit1 restart run first), result (hex)
2
8000 0 0000000000000000
8001 0 0000000000000000
8000 0 0000000000000000
8001 0 0000000000000000
8000 0 0000000000000000
1000 1 8B9A74ABE124B63A
1000 1 0017462664E1B3AC
5044 1 B9A74ABE124B63A8
0800 0 0000000000000000
5808 1 9A74ABE124B63A8B
8001 0 0000000000000000
5010 1 462664E1B3AC0017
1000 1 8B9A74ABE124B63A
8000 0 0000000000000000
7008 1 9A74ABE124B63A8B
1000 1 0017462664E1B3AC
5020 1 64E1B3AC00174626
5040 1 8B9A74ABE124B63A
2000 0 0000000000000000
1000 1 0000000000000000
0000 0 0000000000000000
0000 0 0000000000000000
0000 0 0000000000000000
1000 1 8B8D328D85C50596
1000 3 0017462664E1B3AC

//--- files.f
+incdir+logic
logic/hdc_hv_pkg.sv
logic/hdc_isa_pkg.sv
logic/xorshift_prng.sv
logic/item_fill.sv
logic/hv_thread_regs.sv
logic/hdc_core.sv
logic/hdc_top.sv
dv/hdc_assert.sv
dv/hdc_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= hdc_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
